// ==== src/io_bus_pkg.sv ====
// IO bus widths and device address map
package io_bus_pkg;

   ////////////////////
   // bus geometry

   localparam int ADDR_W = 32;   // byte address
   localparam int DATA_W = 64;   // one bus word
   localparam int SEL_W  = DATA_W / 8;   // byte lanes

   ////////////////////
   // device map

   // region hit compares the address bits above the mask boundary
   localparam logic [ADDR_W-1:0] REGION_MASK = 32'hFFFF_0000;

   localparam logic [ADDR_W-1:0] BRAM_BASE = 32'h0000_0000;
   localparam logic [ADDR_W-1:0] IRQ_BASE  = 32'h0001_0000;

   ////////////////////
   // interrupt register offsets within IRQ_BASE

   localparam logic [ADDR_W-1:0] IRQ_PEND_OFS = 32'h0000_0000;   // write one to clear
   localparam logic [ADDR_W-1:0] IRQ_EN_OFS   = 32'h0000_0008;

endpackage

// ==== src/bram_pkg.sv ====
// block RAM line geometry and line union
package bram_pkg;

   localparam int LINE_W         = 128;   // stored line
   localparam int WORDS_PER_LINE = LINE_W / io_bus_pkg::DATA_W;
   localparam int WORD_SEL_BIT   = 3;     // picks the word inside a line

   // one RAM line, moved as a whole or picked apart by bus word
   typedef union packed {
      logic [LINE_W-1:0]                                    flat;
      logic [WORDS_PER_LINE-1:0][io_bus_pkg::DATA_W-1:0]    word;
   } bram_line_u;

endpackage

// ==== src/io_arbiter.sv ====
// round-robin arbiter sharing one IO bus between two masters
module io_arbiter (
   input  logic                              ram_clk,
   input  logic                              reset_i,
   // m0, processor side
   input  logic                              m0_cyc_i,
   input  logic                              m0_stb_i,
   input  logic                              m0_we_i,
   input  logic [io_bus_pkg::ADDR_W-1:0]     m0_adr_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     m0_dat_i,
   input  logic [io_bus_pkg::SEL_W-1:0]      m0_sel_i,
   output logic                              m0_ack_o,
   output logic                              m0_err_o,
   output logic [io_bus_pkg::DATA_W-1:0]     m0_dat_o,
   // m1, host side
   input  logic                              m1_cyc_i,
   input  logic                              m1_stb_i,
   input  logic                              m1_we_i,
   input  logic [io_bus_pkg::ADDR_W-1:0]     m1_adr_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     m1_dat_i,
   input  logic [io_bus_pkg::SEL_W-1:0]      m1_sel_i,
   output logic                              m1_ack_o,
   output logic                              m1_err_o,
   output logic [io_bus_pkg::DATA_W-1:0]     m1_dat_o,
   // shared bus
   output logic                              bus_cyc_o,
   output logic                              bus_stb_o,
   output logic                              bus_we_o,
   output logic [io_bus_pkg::ADDR_W-1:0]     bus_adr_o,
   output logic [io_bus_pkg::DATA_W-1:0]     bus_dat_o,
   output logic [io_bus_pkg::SEL_W-1:0]      bus_sel_o,
   input  logic                              bus_ack_i,
   input  logic                              bus_err_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     bus_dat_i
);

   logic [1:0] gnt_q;     // one-hot, bit 1 is m1
   logic       last_q;    // 1 when m1 was served last
   logic       idle;

   // bus is free when nobody holds it or the holder let cyc go
   assign idle = ~((gnt_q[0] & m0_cyc_i) | (gnt_q[1] & m1_cyc_i));

   always_ff @(posedge ram_clk) begin
      if (reset_i) begin
         gnt_q  <= 2'b00;
         last_q <= 1'b0;
      end else if (idle) begin
         if (m0_cyc_i && m1_cyc_i) begin
            gnt_q  <= last_q ? 2'b01 : 2'b10;   // the other one's turn
            last_q <= ~last_q;
         end else if (m0_cyc_i) begin
            gnt_q  <= 2'b01;
            last_q <= 1'b0;
         end else if (m1_cyc_i) begin
            gnt_q  <= 2'b10;
            last_q <= 1'b1;
         end else begin
            gnt_q  <= 2'b00;
         end
      end
   end

   ////////////////////
   // request and response routing

   assign bus_cyc_o = (gnt_q[0] & m0_cyc_i) | (gnt_q[1] & m1_cyc_i);
   assign bus_stb_o = (gnt_q[0] & m0_stb_i) | (gnt_q[1] & m1_stb_i);
   assign bus_we_o  = gnt_q[1] ? m1_we_i  : m0_we_i;
   assign bus_adr_o = gnt_q[1] ? m1_adr_i : m0_adr_i;
   assign bus_dat_o = gnt_q[1] ? m1_dat_i : m0_dat_i;
   assign bus_sel_o = gnt_q[1] ? m1_sel_i : m0_sel_i;

   assign m0_ack_o = gnt_q[0] & bus_ack_i;
   assign m0_err_o = gnt_q[0] & bus_err_i;
   assign m0_dat_o = gnt_q[0] ? bus_dat_i : '0;
   assign m1_ack_o = gnt_q[1] & bus_ack_i;
   assign m1_err_o = gnt_q[1] & bus_err_i;
   assign m1_dat_o = gnt_q[1] ? bus_dat_i : '0;

   a_gnt_onehot: assert property (@(posedge ram_clk) disable iff (reset_i)
      !(gnt_q[0] && gnt_q[1]));

   // the granted master must still hold its cycle open
   a_stb_granted: assert property (@(posedge ram_clk) disable iff (reset_i)
      $rose(bus_stb_o) |-> bus_cyc_o);

endmodule

// ==== src/io_decoder.sv ====
// IO address decoder with slave select, response return and unmapped error
module io_decoder #(
   parameter int BRAM_BYTES = 4096
) (
   input  logic                              ram_clk,
   input  logic                              reset_i,
   input  logic                              bus_stb_i,
   input  logic [io_bus_pkg::ADDR_W-1:0]     bus_adr_i,
   output logic                              bus_ack_o,
   output logic                              bus_err_o,
   output logic [io_bus_pkg::DATA_W-1:0]     bus_dat_o,
   output logic                              bram_stb_o,
   input  logic                              bram_ack_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     bram_dat_i,
   output logic                              irq_stb_o,
   input  logic                              irq_ack_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     irq_dat_i
);

   localparam logic [io_bus_pkg::ADDR_W-1:0] BRAM_TOP = BRAM_BYTES;

   logic [io_bus_pkg::ADDR_W-1:0] region;
   logic [io_bus_pkg::ADDR_W-1:0] offset;
   logic                          bram_hit;
   logic                          irq_hit;
   logic                          err_q;

   assign region = bus_adr_i & io_bus_pkg::REGION_MASK;
   assign offset = bus_adr_i & ~io_bus_pkg::REGION_MASK;

   // RAM region only counts below the configured size
   assign bram_hit = (region == io_bus_pkg::BRAM_BASE) && (offset < BRAM_TOP);
   assign irq_hit  = (region == io_bus_pkg::IRQ_BASE);

   assign bram_stb_o = bus_stb_i & bram_hit;
   assign irq_stb_o  = bus_stb_i & irq_hit;

   ////////////////////
   // error slave for everything else

   always_ff @(posedge ram_clk) begin
      if (reset_i)
         err_q <= 1'b0;
      else
         err_q <= bus_stb_i & ~bram_hit & ~irq_hit & ~err_q;   // one pulse
   end

   // address is held until the response, so the hit picks the return path
   assign bus_ack_o = (bram_hit & bram_ack_i) | (irq_hit & irq_ack_i);
   assign bus_err_o = err_q;
   assign bus_dat_o = bram_hit ? bram_dat_i : irq_dat_i;

   a_one_slave: assert property (@(posedge ram_clk) disable iff (reset_i)
      !(bram_stb_o && irq_stb_o));

endmodule

// ==== src/line_bram.sv ====
// block RAM of 128-bit lines with word select and byte-lane writes
module line_bram #(
   parameter int BRAM_BYTES = 4096
) (
   input  logic                              ram_clk,
   input  logic                              reset_i,
   input  logic                              stb_i,
   input  logic                              we_i,
   input  logic [io_bus_pkg::ADDR_W-1:0]     adr_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     dat_i,
   input  logic [io_bus_pkg::SEL_W-1:0]      sel_i,
   output logic                              ack_o,
   output logic [io_bus_pkg::DATA_W-1:0]     dat_o
);

   localparam int LINES    = BRAM_BYTES / (bram_pkg::LINE_W / 8);
   localparam int IDX_W    = (LINES > 1) ? $clog2(LINES) : 1;
   localparam int WSEL_W   = (bram_pkg::WORDS_PER_LINE > 1) ?
                             $clog2(bram_pkg::WORDS_PER_LINE) : 1;
   localparam int LINE_LSB = bram_pkg::WORD_SEL_BIT + WSEL_W;

   bram_pkg::bram_line_u mem [LINES];

   bram_pkg::bram_line_u rd_line_q;
   logic [WSEL_W-1:0]    wsel_q;
   logic                 ack_q;
   logic                 acc;
   logic [IDX_W-1:0]     idx;
   logic [WSEL_W-1:0]    wsel;

   assign acc  = stb_i & ~ack_q;   // once per transfer
   assign idx  = adr_i[LINE_LSB +: IDX_W];
   assign wsel = adr_i[bram_pkg::WORD_SEL_BIT +: WSEL_W];

   ////////////////////
   // storage

   always_ff @(posedge ram_clk) begin
      if (acc) begin
         if (we_i) begin
            // only the addressed word, only enabled lanes
            for (int b = 0; b < io_bus_pkg::SEL_W; b++) begin
               if (sel_i[b])
                  mem[idx].word[wsel][b*8 +: 8] <= dat_i[b*8 +: 8];
            end
         end
         rd_line_q.flat <= mem[idx].flat;
         wsel_q         <= wsel;
      end
   end

   ////////////////////
   // handshake

   always_ff @(posedge ram_clk) begin
      if (reset_i)
         ack_q <= 1'b0;
      else
         ack_q <= acc;
   end

   assign ack_o = ack_q;
   assign dat_o = rd_line_q.word[wsel_q];   // word picked from the held line

   a_ack_pulse: assert property (@(posedge ram_clk) disable iff (reset_i)
      ack_o |=> !ack_o);

endmodule

// ==== src/irq_regs.sv ====
// interrupt pending and enable registers with combined request
module irq_regs #(
   parameter int IRQ_N = 2
) (
   input  logic                              ram_clk,
   input  logic                              reset_i,
   input  logic                              stb_i,
   input  logic                              we_i,
   input  logic [io_bus_pkg::ADDR_W-1:0]     adr_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     dat_i,
   input  logic [io_bus_pkg::SEL_W-1:0]      sel_i,
   input  logic [IRQ_N-1:0]                  irq_src_i,
   output logic                              ack_o,
   output logic [io_bus_pkg::DATA_W-1:0]     dat_o,
   output logic                              irq_o
);

   logic [IRQ_N-1:0]              pend_q;
   logic [IRQ_N-1:0]              en_q;
   logic [IRQ_N-1:0]              clr;
   logic [io_bus_pkg::DATA_W-1:0] rd_q;
   logic [io_bus_pkg::ADDR_W-1:0] ofs;
   logic                          ack_q;
   logic                          acc;
   logic                          wr;

   assign ofs = adr_i & ~io_bus_pkg::REGION_MASK;
   assign acc = stb_i & ~ack_q;
   assign wr  = acc & we_i & sel_i[0];   // lane 0 carries the write

   assign clr = (wr && ofs == io_bus_pkg::IRQ_PEND_OFS) ? dat_i[IRQ_N-1:0] : '0;

   always_ff @(posedge ram_clk) begin
      if (reset_i) begin
         pend_q <= '0;
         en_q   <= '0;
         ack_q  <= 1'b0;
      end else begin
         pend_q <= (pend_q & ~clr) | irq_src_i;   // live source beats the clear
         if (wr && ofs == io_bus_pkg::IRQ_EN_OFS)
            en_q <= dat_i[IRQ_N-1:0];
         ack_q <= acc;
      end
   end

   // read mux, zero for unused offsets
   always_ff @(posedge ram_clk) begin
      if (acc) begin
         if (ofs == io_bus_pkg::IRQ_PEND_OFS)
            rd_q <= io_bus_pkg::DATA_W'(pend_q);
         else if (ofs == io_bus_pkg::IRQ_EN_OFS)
            rd_q <= io_bus_pkg::DATA_W'(en_q);
         else
            rd_q <= '0;
      end
   end

   assign ack_o = ack_q;
   assign dat_o = rd_q;
   assign irq_o = |(pend_q & en_q);

endmodule

// ==== src/io_subsystem.sv ====
// IO subsystem top with arbiter, decoder, block RAM and interrupt registers
module io_subsystem #(
   parameter int BRAM_BYTES = 4096,
   parameter int IRQ_N      = 2
) (
   input  logic                              ram_clk,
   input  logic                              reset_i,
   input  logic                              m0_cyc_i,
   input  logic                              m0_stb_i,
   input  logic                              m0_we_i,
   input  logic [io_bus_pkg::ADDR_W-1:0]     m0_adr_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     m0_dat_i,
   input  logic [io_bus_pkg::SEL_W-1:0]      m0_sel_i,
   output logic                              m0_ack_o,
   output logic                              m0_err_o,
   output logic [io_bus_pkg::DATA_W-1:0]     m0_dat_o,
   input  logic                              m1_cyc_i,
   input  logic                              m1_stb_i,
   input  logic                              m1_we_i,
   input  logic [io_bus_pkg::ADDR_W-1:0]     m1_adr_i,
   input  logic [io_bus_pkg::DATA_W-1:0]     m1_dat_i,
   input  logic [io_bus_pkg::SEL_W-1:0]      m1_sel_i,
   output logic                              m1_ack_o,
   output logic                              m1_err_o,
   output logic [io_bus_pkg::DATA_W-1:0]     m1_dat_o,
   input  logic [IRQ_N-1:0]                  irq_src_i,
   output logic                              irq_o
);

   // RAM read word is one slice of a stored line
   localparam int WORD_W = $bits(bram_pkg::bram_line_u) / bram_pkg::WORDS_PER_LINE;

   ////////////////////
   // shared bus

   logic                          bus_stb, bus_we, bus_ack, bus_err;
   logic [io_bus_pkg::ADDR_W-1:0] bus_adr;
   logic [io_bus_pkg::DATA_W-1:0] bus_wdat, bus_rdat;
   logic [io_bus_pkg::SEL_W-1:0]  bus_sel;

   logic              bram_stb, bram_ack;
   logic [WORD_W-1:0] bram_dat;
   logic                          irq_stb, irq_ack;
   logic [io_bus_pkg::DATA_W-1:0] irq_dat;

   io_arbiter arb_i (
      .ram_clk(ram_clk), .reset_i(reset_i),
      .m0_cyc_i(m0_cyc_i), .m0_stb_i(m0_stb_i), .m0_we_i(m0_we_i),
      .m0_adr_i(m0_adr_i), .m0_dat_i(m0_dat_i), .m0_sel_i(m0_sel_i),
      .m0_ack_o(m0_ack_o), .m0_err_o(m0_err_o), .m0_dat_o(m0_dat_o),
      .m1_cyc_i(m1_cyc_i), .m1_stb_i(m1_stb_i), .m1_we_i(m1_we_i),
      .m1_adr_i(m1_adr_i), .m1_dat_i(m1_dat_i), .m1_sel_i(m1_sel_i),
      .m1_ack_o(m1_ack_o), .m1_err_o(m1_err_o), .m1_dat_o(m1_dat_o),
      .bus_cyc_o(), .bus_stb_o(bus_stb), .bus_we_o(bus_we),
      .bus_adr_o(bus_adr), .bus_dat_o(bus_wdat), .bus_sel_o(bus_sel),
      .bus_ack_i(bus_ack), .bus_err_i(bus_err), .bus_dat_i(bus_rdat)
   );

   io_decoder #(.BRAM_BYTES(BRAM_BYTES)) dec_i (
      .ram_clk(ram_clk), .reset_i(reset_i),
      .bus_stb_i(bus_stb), .bus_adr_i(bus_adr),
      .bus_ack_o(bus_ack), .bus_err_o(bus_err), .bus_dat_o(bus_rdat),
      .bram_stb_o(bram_stb), .bram_ack_i(bram_ack), .bram_dat_i(bram_dat),
      .irq_stb_o(irq_stb), .irq_ack_i(irq_ack), .irq_dat_i(irq_dat)
   );

   line_bram #(.BRAM_BYTES(BRAM_BYTES)) bram_i (
      .ram_clk(ram_clk), .reset_i(reset_i),
      .stb_i(bram_stb), .we_i(bus_we), .adr_i(bus_adr),
      .dat_i(bus_wdat), .sel_i(bus_sel),
      .ack_o(bram_ack), .dat_o(bram_dat)
   );

   irq_regs #(.IRQ_N(IRQ_N)) irq_i (
      .ram_clk(ram_clk), .reset_i(reset_i),
      .stb_i(irq_stb), .we_i(bus_we), .adr_i(bus_adr),
      .dat_i(bus_wdat), .sel_i(bus_sel), .irq_src_i(irq_src_i),
      .ack_o(irq_ack), .dat_o(irq_dat), .irq_o(irq_o)
   );

endmodule

// ==== bench/tb_io.sv ====
// testbench for the IO subsystem with RAM and interrupt model, random traffic and watchdog
module tb_io;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RAM_B  = 4096;
   localparam int N_RAND = 200;
   localparam int N_ERR  = 32;
   localparam int N_IRQ  = 8;
   localparam int N_CONC = 150;
   // every transfer counted once, irq rounds take four plus a pulse
   localparam int N_XFER = 2 + 2 * (RAM_B / 8) + N_RAND + 2 * N_ERR + 5 * N_IRQ + 2 * N_CONC;

   logic        ram_clk = 1'b0;
   logic        reset_i;
   logic [1:0]  cyc, stb, we, ack, err;
   logic [31:0] adr [2];
   logic [63:0] wdat [2];
   logic [63:0] rdat [2];
   logic [7:0]  sel [2];
   logic [1:0]  irq_src;
   logic        irq_o;

   logic [7:0]  ram_m [RAM_B];   // byte image of the RAM
   logic [1:0]  pend_m;
   logic [1:0]  en_m;
   int          checks = 0;
   int          errors = 0;
   int          mark = 0;

   io_subsystem dut_i (
      .ram_clk(ram_clk), .reset_i(reset_i),
      .m0_cyc_i(cyc[0]), .m0_stb_i(stb[0]), .m0_we_i(we[0]), .m0_adr_i(adr[0]),
      .m0_dat_i(wdat[0]), .m0_sel_i(sel[0]), .m0_ack_o(ack[0]), .m0_err_o(err[0]),
      .m0_dat_o(rdat[0]),
      .m1_cyc_i(cyc[1]), .m1_stb_i(stb[1]), .m1_we_i(we[1]), .m1_adr_i(adr[1]),
      .m1_dat_i(wdat[1]), .m1_sel_i(sel[1]), .m1_ack_o(ack[1]), .m1_err_o(err[1]),
      .m1_dat_o(rdat[1]),
      .irq_src_i(irq_src), .irq_o(irq_o)
   );

   initial begin
      forever #4 ram_clk = ~ram_clk;
   end

   initial begin
      #(N_XFER * 20 * 8);
      $display("Timeout: the bus stopped answering before all transfers were done");
      $display("Errors found");
      $finish;
   end

   ////////////////////
   // checks and model

   task automatic compare_word(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
      checks++;
      assert (got === exp)
      else begin
         $display("Error %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic require(input logic ok, input string what);
      checks++;
      assert (ok)
      else begin
         $display("%0t: %s", $time, what);
         errors++;
      end
   endtask

   task automatic test_done(input string name);
      $display("%s: finished, %0d errors", name, errors - mark);
      mark = errors;
   endtask

   function automatic logic [63:0] model_word(input logic [31:0] a);
      logic [63:0] w;
      logic [11:0] ix;
      for (int b = 0; b < 8; b++) begin
         ix = a[11:0] + 12'(b);
         w[b*8 +: 8] = ram_m[ix];   // lane b is byte a+b
      end
      return w;
   endfunction

   function automatic void model_write(input logic [31:0] a, input logic [63:0] d,
                                       input logic [7:0] s);
      logic [11:0] ix;
      for (int b = 0; b < 8; b++) begin
         ix = a[11:0] + 12'(b);
         if (s[b])
            ram_m[ix] = d[b*8 +: 8];
      end
   endfunction

   ////////////////////
   // bus master

   // starts on a falling edge and returns one clean cycle after the response
   task automatic transfer(input logic m, input logic w, input logic [31:0] a,
                           input logic [63:0] d, input logic [7:0] s,
                           output logic [63:0] r, output logic e);
      cyc[m] = 1'b1;
      stb[m] = 1'b1;
      we[m] = w;
      adr[m] = a;
      wdat[m] = d;
      sel[m] = s;
      do @(negedge ram_clk); while (!ack[m] && !err[m]);
      require(!(ack[m] && err[m]), $sformatf("m%0d got ack and err together", m));
      r = rdat[m];
      e = err[m];
      cyc[m] = 1'b0;
      stb[m] = 1'b0;
      @(negedge ram_clk);
      require(!ack[m] && !err[m], $sformatf("m%0d got a second response at %h", m, a));
   endtask

   task automatic ram_access(input logic m, input logic w, input logic [31:0] a,
                             input logic [63:0] d, input logic [7:0] s);
      logic [63:0] r;
      logic        e;
      transfer(m, w, a, d, s, r, e);
      require(!e, $sformatf("RAM access at %h was rejected with err", a));
      if (w)
         model_write(a, d, s);
      else
         compare_word(r, model_word(a), $sformatf("m%0d RAM word %h", m, a));
   endtask

   task automatic irq_access(input logic w, input logic [31:0] ofs, input logic [1:0] v,
                             input string what);
      logic [63:0] r;
      logic        e;
      transfer(1'b0, w, io_bus_pkg::IRQ_BASE + ofs, 64'(v), 8'hFF, r, e);
      require(!e, $sformatf("interrupt register %h was rejected with err", ofs));
      if (!w)
         compare_word(r, 64'(v), what);   // v is the expected value on reads
   endtask

   task automatic random_traffic(input logic m);
      logic [31:0] base;
      base = m ? 32'(RAM_B / 2) : 32'd0;   // each master owns half the RAM
      repeat (N_CONC)
         ram_access(m, 1'($urandom),
                    base + (32'($urandom_range(RAM_B / 16 - 1, 0)) << 3),
                    {$urandom, $urandom}, 8'($urandom));
   endtask

   ////////////////////
   // test sequence

   initial begin
      logic [63:0] r;
      logic        e;
      logic [31:0] a;
      logic [1:0]  hold;
      logic [1:0]  clr;
      void'($urandom(32'hda75));
      reset_i = 1'b1;
      cyc = '0;
      stb = '0;
      we = '0;
      irq_src = '0;
      adr = '{default: '0};
      wdat = '{default: '0};
      sel = '{default: '0};
      pend_m = '0;
      en_m = '0;
      repeat (5) @(negedge ram_clk);
      reset_i = 1'b0;

      require(ack == 2'b00 && err == 2'b00, "a master saw a response right after reset");
      compare_word({63'b0, irq_o}, 64'b0, "irq_o after reset");
      irq_access(1'b0, io_bus_pkg::IRQ_PEND_OFS, 2'b00, "pending after reset");
      irq_access(1'b0, io_bus_pkg::IRQ_EN_OFS, 2'b00, "enable after reset");
      test_done("reset state");

      for (int i = 0; i < RAM_B / 8; i++) begin
         a = 32'(i * 8);
         ram_access(1'b0, 1'b1, a, {a, ~a}, 8'hFF);   // fill, tied to the address
      end
      repeat (N_RAND)
         ram_access(1'b0, 1'b1, 32'($urandom_range(RAM_B / 8 - 1, 0)) << 3,
                    {$urandom, $urandom}, 8'($urandom));
      for (int i = 0; i < RAM_B / 8; i++)
         ram_access(1'b0, 1'b0, 32'(i * 8), '0, 8'hFF);
      test_done("RAM byte-lane writes");

      for (int i = 0; i < N_ERR; i++) begin
         if (i % 2 == 0)
            a = {16'($urandom_range(32'hFFFF, 2)), 16'($urandom) & 16'hFFF8};
         else
            a = {16'h0, 16'($urandom_range(32'hFFFF, RAM_B)) & 16'hFFF8};
         transfer(1'b0, (i % 4 == 1), a, {$urandom, $urandom}, 8'hFF, r, e);
         require(e, $sformatf("address %h was acknowledged instead of rejected", a));
         ram_access(1'b0, 1'b0, {20'b0, a[11:0]}, '0, 8'hFF);   // aliased word untouched
      end
      test_done("unmapped addresses");

      for (int i = 0; i < N_IRQ; i++) begin
         en_m = 2'($urandom);
         irq_access(1'b1, io_bus_pkg::IRQ_EN_OFS, en_m, "");
         irq_src = 2'($urandom);
         pend_m = pend_m | irq_src;
         @(negedge ram_clk);
         irq_src = '0;
         compare_word({63'b0, irq_o}, {63'b0, |(pend_m & en_m)}, "irq_o after pulse");
         irq_access(1'b0, io_bus_pkg::IRQ_PEND_OFS, pend_m, "pending after pulse");
         hold = 2'($urandom);
         clr = 2'($urandom);
         irq_src = hold;   // a live source survives the clear
         irq_access(1'b1, io_bus_pkg::IRQ_PEND_OFS, clr, "");
         irq_src = '0;
         pend_m = (pend_m & ~clr) | hold;
         compare_word({63'b0, irq_o}, {63'b0, |(pend_m & en_m)}, "irq_o after clear");
         irq_access(1'b0, io_bus_pkg::IRQ_PEND_OFS, pend_m, "pending after clear");
      end
      test_done("interrupts");

      fork
         random_traffic(1'b0);
         random_traffic(1'b1);
      join
      test_done("two masters");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

// ==== list.f ====
src/io_bus_pkg.sv
src/bram_pkg.sv
src/io_arbiter.sv
src/io_decoder.sv
src/line_bram.sv
src/irq_regs.sv
src/io_subsystem.sv
bench/tb_io.sv

// ==== run.sh ====
#!/bin/sh
# build and run the IO subsystem testbench with Verilator
set -e
verilator --binary --timing --assert -j 0 --top-module tb_io -f list.f -o tb_io_sim
./obj_dir/tb_io_sim > sim.log 2>&1
cat sim.log
if grep -qx "No errors" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
